// File: hdl/decode_pkg.sv
////////////////////////////////////////////////////////////
// Shared types of the stage 0 decoder. Window byte 0 sits in
// the top byte of every window word. Fields are left-aligned.
////////////////////////////////////////////////////////////

package decode_pkg;

   localparam int unsigned addr_w         = 32;
   localparam int unsigned window_bytes   = 16;
   localparam int unsigned max_insn_bytes = 15;

   // Fetch side, 166 bits
   typedef struct packed {
      logic [window_bytes*8-1:0] window;
      logic [4:0]                valid_bytes;
      logic [addr_w-1:0]         pc;
      logic                      branch_taken;
   } fetch_bundle_t;

   // Opcode table lookup, 27 bits
   typedef struct packed {
      logic [15:0] opcode;
      logic [1:0]  opcode_bytes;
      logic        has_modrm;
      logic [2:0]  imm_bytes;
      logic [2:0]  rom_control;
      logic        rom_in_control;
      logic        is_halt;
   } opcode_info_t;

   // ModRM then SIB, 21 bits
   typedef struct packed {
      logic [15:0] addressing;
      logic [1:0]  addressing_bytes;
      logic [2:0]  disp_bytes;
   } addressing_info_t;

   // Stage 0 pipe, 170 bits
   typedef struct packed {
      logic [23:0]       prefix;
      logic [1:0]        prefix_bytes;
      logic              size_override;
      logic [15:0]       opcode;
      logic [1:0]        opcode_bytes;
      logic [15:0]       addressing;
      logic [1:0]        addressing_bytes;
      logic [2:0]        disp_bytes;
      logic [2:0]        imm_bytes;
      // Displacement first, then immediate
      logic [63:0]       disp_n_imm;
      logic [2:0]        rom_control;
      logic              rom_in_control;
      logic [addr_w-1:0] pc;
      logic              branch_taken;
   } stage0_bundle_t;

endpackage

// File: hdl/prefix_scan.sv
////////////////////////////////////////////////////////////
// Counts up to three leading legacy prefixes. The 67 prefix
// is not recognised and ends the scan like any opcode byte.
////////////////////////////////////////////////////////////

module prefix_scan (
   input  logic [23:0] window,
   output logic [1:0]  prefix_bytes,
   output logic        size_override
);

   logic [7:0] byte_0, byte_1, byte_2;
   logic       run_0, run_1, run_2;

   function automatic logic is_prefix(input logic [7:0] b);
      case (b)
         8'h66, 8'hF0, 8'hF2, 8'hF3: is_prefix = 1'b1;
         // Segment overrides
         8'h26, 8'h2E, 8'h36, 8'h3E, 8'h64, 8'h65: is_prefix = 1'b1;
         default: is_prefix = 1'b0;
      endcase
   endfunction

   assign byte_0 = window[23:16];
   assign byte_1 = window[15:8];
   assign byte_2 = window[7:0];

   // Prefixes only count while the run is unbroken
   assign run_0 = is_prefix(byte_0);
   assign run_1 = run_0 & is_prefix(byte_1);
   assign run_2 = run_1 & is_prefix(byte_2);

   assign prefix_bytes = run_2 ? 2'd3 :
                         run_1 ? 2'd2 :
                         run_0 ? 2'd1 : 2'd0;

   assign size_override = (run_0 && byte_0 == 8'h66) ||
                          (run_1 && byte_1 == 8'h66) ||
                          (run_2 && byte_2 == 8'h66);

endmodule

// File: hdl/opcode_decode.sv
////////////////////////////////////////////////////////////
// Opcode table for the supported subset. Anything else is
// a one byte opcode with no ModRM and no immediate.
////////////////////////////////////////////////////////////

module opcode_decode (
   input  logic [15:0]               opcode_window,
   input  logic                      size_override,
   output decode_pkg::opcode_info_t  info
);

   logic [7:0] first_byte;
   logic [7:0] second_byte;
   logic       escape;
   logic [2:0] full_imm;

   assign first_byte  = opcode_window[15:8];
   assign second_byte = opcode_window[7:0];
   assign escape      = (first_byte == 8'h0F);

   // Word or dword immediate, picked by 66
   assign full_imm = size_override ? 3'd2 : 3'd4;

   always_comb begin
      info              = '0;
      info.opcode_bytes = escape ? 2'd2 : 2'd1;
      info.opcode       = escape ? opcode_window : {first_byte, 8'h00};

      if (escape) begin
         case (second_byte) inside
            // IMUL r, r/m
            8'hAF: begin
               info.has_modrm = 1'b1;
            end
            // Jcc rel
            [8'h80:8'h8F]: begin
               info.imm_bytes = full_imm;
            end
            default: ;
         endcase
      end else begin
         case (first_byte) inside
            8'h00, 8'h01, 8'h02, 8'h03, [8'h88:8'h8B]: begin
               info.has_modrm = 1'b1;
            end
            8'h04, 8'hEB: begin
               info.imm_bytes = 3'd1;
            end
            8'h05, [8'hB8:8'hBF]: begin
               info.imm_bytes = full_imm;
            end
            // CALL goes through the ROM
            8'hE8: begin
               info.imm_bytes      = full_imm;
               info.rom_in_control = 1'b1;
               info.rom_control    = 3'd1;
            end
            8'hC3: begin
               info.rom_in_control = 1'b1;
               info.rom_control    = 3'd2;
            end
            8'hC6: begin
               info.has_modrm = 1'b1;
               info.imm_bytes = 3'd1;
            end
            8'hC7: begin
               info.has_modrm = 1'b1;
               info.imm_bytes = full_imm;
            end
            8'hF4: begin
               info.is_halt = 1'b1;
            end
            // NOP and unknown opcodes
            default: ;
         endcase
      end
   end

endmodule

// File: hdl/modrm_decode.sv
////////////////////////////////////////////////////////////
// 32-bit addressing forms only. Displacement is 0, 1 or 4
// bytes and an SIB byte follows rm 100 in memory forms.
////////////////////////////////////////////////////////////

module modrm_decode (
   input  logic [15:0]                   addressing_window,
   input  logic                          has_modrm,
   output decode_pkg::addressing_info_t  info
);

   logic [1:0] mode;
   logic [2:0] rm;
   logic [2:0] sib_base;
   logic       has_sib;

   assign mode     = addressing_window[15:14];
   assign rm       = addressing_window[10:8];
   assign sib_base = addressing_window[2:0];
   assign has_sib  = has_modrm && mode != 2'b11 && rm == 3'b100;

   always_comb begin
      info = '0;
      if (has_modrm) begin
         info.addressing_bytes = has_sib ? 2'd2 : 2'd1;
         info.addressing       = has_sib ? addressing_window
                                         : {addressing_window[15:8], 8'h00};
         case (mode)
            2'b01: info.disp_bytes = 3'd1;
            2'b10: info.disp_bytes = 3'd4;
            // disp32 without base, direct or through SIB
            2'b00: begin
               if (rm == 3'b101 || (has_sib && sib_base == 3'b101))
                  info.disp_bytes = 3'd4;
            end
            default: info.disp_bytes = 3'd0;
         endcase
      end
   end

   always_comb begin
      assert (info.disp_bytes inside {3'd0, 3'd1, 3'd4})
         else $error("illegal displacement size %0d", info.disp_bytes);
   end

endmodule

// File: hdl/field_align.sv
////////////////////////////////////////////////////////////
// Aligns each field to the top of its word. pc and
// branch_taken of s0 are left at zero here.
////////////////////////////////////////////////////////////

module field_align (
   input  logic [127:0]                  window,
   input  logic [1:0]                    prefix_bytes,
   input  logic                          size_override,
   input  decode_pkg::opcode_info_t      opcode_info,
   input  decode_pkg::addressing_info_t  addressing_info,
   output logic [15:0]                   opcode_window,
   output logic [15:0]                   addressing_window,
   output logic [4:0]                    length,
   output decode_pkg::stage0_bundle_t    s0
);

   logic [2:0]   po_bytes;
   logic [2:0]   poa_bytes;
   logic [3:0]   disp_imm_bytes;
   logic [127:0] after_prefix, after_opcode, after_addressing;

   // Running byte offsets, at most 3 + 2 + 2
   assign po_bytes       = {1'b0, prefix_bytes} + {1'b0, opcode_info.opcode_bytes};
   assign poa_bytes      = po_bytes + {1'b0, addressing_info.addressing_bytes};
   assign disp_imm_bytes = {1'b0, addressing_info.disp_bytes} + {1'b0, opcode_info.imm_bytes};
   assign length         = {2'b00, poa_bytes} + {1'b0, disp_imm_bytes};

   assign after_prefix     = window << {prefix_bytes, 3'b000};
   assign after_opcode     = window << {po_bytes, 3'b000};
   assign after_addressing = window << {poa_bytes, 3'b000};

   assign opcode_window     = after_prefix[127:112];
   assign addressing_window = after_opcode[127:112];

   always_comb begin
      s0                  = '0;
      // Only the counted prefix bytes, left-aligned
      s0.prefix           = window[127:104] & ~(24'hFF_FFFF >> {prefix_bytes, 3'b000});
      s0.prefix_bytes     = prefix_bytes;
      s0.size_override    = size_override;
      s0.opcode           = opcode_info.opcode;
      s0.opcode_bytes     = opcode_info.opcode_bytes;
      s0.addressing       = addressing_info.addressing;
      s0.addressing_bytes = addressing_info.addressing_bytes;
      s0.disp_bytes       = addressing_info.disp_bytes;
      s0.imm_bytes        = opcode_info.imm_bytes;
      s0.disp_n_imm       = after_addressing[127:64];
      s0.rom_control      = opcode_info.rom_control;
      s0.rom_in_control   = opcode_info.rom_in_control;
   end

   always_comb begin
      assert (length <= 5'(decode_pkg::max_insn_bytes))
         else $error("instruction length %0d too long", length);
   end

endmodule

// File: hdl/decode_control.sv
////////////////////////////////////////////////////////////
// Valid/ready gating for one instruction at a time. Halt is
// the only state and needs flush or handle_int to clear.
////////////////////////////////////////////////////////////

module decode_control (
   input  logic       clk,
   input  logic       arst_n,
   input  logic       flush,
   input  logic       handle_int,
   input  logic       f_valid,
   input  logic [4:0] valid_bytes,
   input  logic [4:0] length,
   input  logic       is_halt,
   input  logic       s0_ready,
   output logic       f_ready,
   output logic       s0_valid,
   output logic       halt
);

   logic partial;
   logic transfer;
   logic halt_q;

   // Window does not yet hold the whole instruction
   assign partial = (valid_bytes < length);

   assign s0_valid = f_valid & ~partial & ~halt_q;
   assign f_ready  = s0_valid & s0_ready;
   assign transfer = f_ready;
   assign halt     = halt_q;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         halt_q <= 1'b0;
      end else if (flush || handle_int) begin
         halt_q <= 1'b0;
      end else if (transfer && is_halt) begin
         halt_q <= 1'b1;
      end
   end

   // HLT leaving the stage stops the next instruction
   hlt_stops_next: assert property (@(posedge clk) disable iff (!arst_n)
      (transfer && is_halt && !flush && !handle_int) |=> !s0_valid);

   // Held halt keeps valid low
   halt_holds: assert property (@(posedge clk) disable iff (!arst_n)
      (halt && !flush && !handle_int) |=> !s0_valid);

   ready_needs_stage: assert property (@(posedge clk) disable iff (!arst_n)
      f_ready |-> s0_ready);

endmodule

// File: hdl/decode_stage_0.sv
////////////////////////////////////////////////////////////
// Stage 0 of the decoder. Fetch to s0 is combinational and
// f_bytes_read is the decoded length.
////////////////////////////////////////////////////////////

module decode_stage_0 (
   // Clock and reset
   input  logic                       clk,
   input  logic                       arst_n,

   // Control
   input  logic                       flush,
   input  logic                       handle_int,
   output logic                       halt,

   // Fetch side
   input  logic                       f_valid,
   input  decode_pkg::fetch_bundle_t  fetch,
   output logic                       f_ready,
   output logic [4:0]                 f_bytes_read,

   // Stage side
   output logic                       s0_valid,
   output decode_pkg::stage0_bundle_t s0,
   input  logic                       s0_ready
);

   logic [1:0]                   prefix_bytes;
   logic                         size_override;
   logic [15:0]                  opcode_window;
   logic [15:0]                  addressing_window;
   logic [4:0]                   length;
   decode_pkg::opcode_info_t     opcode_info;
   decode_pkg::addressing_info_t addressing_info;
   decode_pkg::stage0_bundle_t   s0_fields;

   prefix_scan u_prefix_scan (
      .window        (fetch.window[127:104]),
      .prefix_bytes  (prefix_bytes),
      .size_override (size_override)
   );

   opcode_decode u_opcode_decode (
      .opcode_window (opcode_window),
      .size_override (size_override),
      .info          (opcode_info)
   );

   modrm_decode u_modrm_decode (
      .addressing_window (addressing_window),
      .has_modrm         (opcode_info.has_modrm),
      .info              (addressing_info)
   );

   field_align u_field_align (
      .window            (fetch.window),
      .prefix_bytes      (prefix_bytes),
      .size_override     (size_override),
      .opcode_info       (opcode_info),
      .addressing_info   (addressing_info),
      .opcode_window     (opcode_window),
      .addressing_window (addressing_window),
      .length            (length),
      .s0                (s0_fields)
   );

   decode_control u_decode_control (
      .clk         (clk),
      .arst_n      (arst_n),
      .flush       (flush),
      .handle_int  (handle_int),
      .f_valid     (f_valid),
      .valid_bytes (fetch.valid_bytes),
      .length      (length),
      .is_halt     (opcode_info.is_halt),
      .s0_ready    (s0_ready),
      .f_ready     (f_ready),
      .s0_valid    (s0_valid),
      .halt        (halt)
   );

   assign f_bytes_read = length;

   // pc and branch_taken ride along from fetch
   always_comb begin
      s0              = s0_fields;
      s0.pc           = fetch.pc;
      s0.branch_taken = fetch.branch_taken;
   end

endmodule

// File: verification/tb_clock.sv
////////////////////////////////////////////////////////////
// Free-running 40 ns clock, low at time zero
////////////////////////////////////////////////////////////

module tb_clock (
   output logic clk
);
   timeunit 1ns;
   timeprecision 100ps;

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

endmodule

// File: verification/decode_stage_0_tb.sv
////////////////////////////////////////////////////////////
// Directed and LFSR-built instructions for decode stage 0.
// Window bytes past the instruction are zero.
////////////////////////////////////////////////////////////

module decode_stage_0_tb;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int random_count    = 150;
   localparam int directed_count  = 50;
   localparam int cycles_per_insn = 2;
   // Tenfold margin over the expected run length
   localparam int max_cycles      = (random_count + directed_count) * cycles_per_insn * 10;
   localparam int handshake_limit = 8;
   localparam int drive_delay     = 2;

   logic                       clk;
   logic                       arst_n;
   logic                       flush;
   logic                       handle_int;
   logic                       f_valid;
   logic                       s0_ready;
   logic                       f_ready;
   logic                       s0_valid;
   logic                       halt;
   logic [4:0]                 f_bytes_read;
   decode_pkg::fetch_bundle_t  fetch;
   decode_pkg::stage0_bundle_t s0;

   // Reference model of the instruction being sent
   logic [7:0]                 insn [$];
   decode_pkg::stage0_bundle_t exp_s0;
   logic [31:0]                next_pc;
   logic [15:0]                lfsr_state;
   string                      test_name;
   int                         test_errors;
   int                         error_count;
   int                         test_count;
   int                         failed_tests;
   int                         cycles = 0;

   tb_clock u_clock (.clk(clk));

   decode_stage_0 dut (
      .clk          (clk),
      .arst_n       (arst_n),
      .flush        (flush),
      .handle_int   (handle_int),
      .halt         (halt),
      .f_valid      (f_valid),
      .fetch        (fetch),
      .f_ready      (f_ready),
      .f_bytes_read (f_bytes_read),
      .s0_valid     (s0_valid),
      .s0           (s0),
      .s0_ready     (s0_ready)
   );

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= max_cycles) begin
         $display("Timeout: the run went past %0d cycles", max_cycles);
         $display("Regression failed");
         $finish;
      end
   end

   // Galois LFSR, taps 16 14 13 11
   function automatic logic [15:0] lfsr_next(input logic [15:0] state);
      logic [15:0] next;
      next = state >> 1;
      if (state[0])
         next = next ^ 16'hB400;
      return next;
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] value;
      value = '0;
      for (int k = 0; k < n; k++) begin
         value      = {value[30:0], lfsr_state[0]};
         lfsr_state = lfsr_next(lfsr_state);
      end
      return value;
   endfunction

   // ModRM presence and immediate size per opcode group
   function automatic void op_class(input logic [7:0] op, input logic [7:0] op2,
                                    input logic ovr, output logic modrm, output int imm);
      int full;
      full  = ovr ? 2 : 4;
      modrm = 1'b0;
      imm   = 0;
      if (op == 8'h0F) begin
         modrm = (op2 == 8'hAF);
         if (op2[7:4] == 4'h8)
            imm = full;
      end else if (op <= 8'h03 || (op >= 8'h88 && op <= 8'h8B)) begin
         modrm = 1'b1;
      end else if (op == 8'h04 || op == 8'hEB) begin
         imm = 1;
      end else if (op == 8'h05 || op == 8'hE8 || op[7:3] == 5'b10111) begin
         imm = full;
      end else if (op == 8'hC6 || op == 8'hC7) begin
         modrm = 1'b1;
         imm   = (op == 8'hC6) ? 1 : full;
      end
   endfunction

   function automatic logic [7:0] pick_prefix(input logic [2:0] i);
      case (i)
         3'd0: return 8'h66;
         3'd1: return 8'hF0;
         3'd2: return 8'hF2;
         3'd3: return 8'hF3;
         3'd4: return 8'h2E;
         3'd5: return 8'h3E;
         3'd6: return 8'h64;
         default: return 8'h26;
      endcase
   endfunction

   // HLT stays out of the random pool
   function automatic logic [7:0] pick_opcode(input logic [3:0] i);
      case (i)
         4'd0: return 8'h00;
         4'd1: return 8'h01;
         4'd2: return 8'h03;
         4'd3: return 8'h04;
         4'd4: return 8'h05;
         4'd5: return 8'h88;
         4'd6: return 8'h89;
         4'd7: return 8'h8B;
         4'd8: return 8'h90;
         4'd9: return 8'hB8;
         4'd10: return 8'hBD;
         4'd11: return 8'hC3;
         4'd12: return 8'hC6;
         4'd13: return 8'hC7;
         4'd14: return 8'hE8;
         default: return 8'hEB;
      endcase
   endfunction

   task automatic next_cycle();
      @(posedge clk);
      #drive_delay;
   endtask

   task automatic start_test(input string name);
      test_name   = name;
      test_errors = 0;
      test_count++;
   endtask

   task automatic finish_test();
      if (test_errors > 0)
         failed_tests++;
      error_count += test_errors;
      $display("%-16s %s", test_name, (test_errors == 0) ? "ok" : "FAILED");
   endtask

   task automatic check_length(input logic [4:0] expected, input logic [4:0] actual);
      if (expected !== actual) begin
         $display("CHECK FAILED %s length: expected %0d actual %0d", test_name, expected, actual);
         test_errors++;
      end
   endtask

   task automatic check_bundle(input decode_pkg::stage0_bundle_t expected,
                               input decode_pkg::stage0_bundle_t actual);
      if (expected !== actual) begin
         $display("CHECK FAILED %s s0: expected %h actual %h", test_name, expected, actual);
         test_errors++;
      end
   endtask

   task automatic check_flag(input string what, input logic expected, input logic actual);
      if (expected !== actual) begin
         $display("CHECK FAILED %s %s: expected %b actual %b", test_name, what, expected, actual);
         test_errors++;
      end
   endtask

   // Builds the bytes and the expected s0 from the field rules
   task automatic build_insn(input logic [23:0] pfx, input int npfx, input logic [7:0] op,
                             input logic [7:0] op2, input logic [7:0] modrm,
                             input logic [7:0] sib);
      logic       ovr;
      logic       has_modrm;
      logic       has_sib;
      int         imm_n;
      int         disp_n;
      logic [7:0] b;
      insn.delete();
      exp_s0 = '0;
      ovr    = 1'b0;
      disp_n = 0;
      for (int k = 0; k < npfx; k++) begin
         b = pfx[23-8*k -: 8];
         insn.push_back(b);
         exp_s0.prefix[23-8*k -: 8] = b;
         ovr = ovr | (b == 8'h66);
      end
      insn.push_back(op);
      exp_s0.opcode       = {op, 8'h00};
      exp_s0.opcode_bytes = 2'd1;
      if (op == 8'h0F) begin
         insn.push_back(op2);
         exp_s0.opcode       = {op, op2};
         exp_s0.opcode_bytes = 2'd2;
      end
      op_class(op, op2, ovr, has_modrm, imm_n);
      if (has_modrm) begin
         has_sib = (modrm[7:6] != 2'b11) && (modrm[2:0] == 3'b100);
         insn.push_back(modrm);
         exp_s0.addressing       = {modrm, 8'h00};
         exp_s0.addressing_bytes = 2'd1;
         if (has_sib) begin
            insn.push_back(sib);
            exp_s0.addressing       = {modrm, sib};
            exp_s0.addressing_bytes = 2'd2;
         end
         if (modrm[7:6] == 2'b01)
            disp_n = 1;
         else if (modrm[7:6] == 2'b10)
            disp_n = 4;
         else if (modrm[7:6] == 2'b00 && (modrm[2:0] == 3'b101 || (has_sib && sib[2:0] == 3'b101)))
            disp_n = 4;
      end
      // Displacement then immediate, random contents
      for (int k = 0; k < disp_n + imm_n; k++) begin
         b = 8'(rand_bits(8));
         insn.push_back(b);
         exp_s0.disp_n_imm[63-8*k -: 8] = b;
      end
      exp_s0.prefix_bytes  = 2'(npfx);
      exp_s0.size_override = ovr;
      exp_s0.disp_bytes    = 3'(disp_n);
      exp_s0.imm_bytes     = 3'(imm_n);
      if (op == 8'hE8 || op == 8'hC3) begin
         exp_s0.rom_in_control = 1'b1;
         exp_s0.rom_control    = (op == 8'hE8) ? 3'd1 : 3'd2;
      end
   endtask

   task automatic drive_window(input int valid_n);
      fetch.window = '0;
      for (int k = 0; k < insn.size(); k++)
         fetch.window[127-8*k -: 8] = insn[k];
      fetch.valid_bytes   = 5'(valid_n);
      fetch.pc            = next_pc;
      fetch.branch_taken  = 1'(rand_bits(1));
      exp_s0.pc           = next_pc;
      exp_s0.branch_taken = fetch.branch_taken;
   endtask

   // Samples at the falling edge, inputs held meanwhile
   task automatic wait_transfer(output logic seen);
      seen = 1'b0;
      for (int n = 0; n < handshake_limit && !seen; n++) begin
         @(negedge clk);
         seen = s0_valid && f_ready;
      end
      if (!seen) begin
         $display("%s: no transfer within %0d cycles", test_name, handshake_limit);
         test_errors++;
      end
   endtask

   // Window already on the bus, it stays until it is taken
   task automatic complete_transfer();
      logic seen;
      f_valid  = 1'b1;
      s0_ready = 1'b1;
      wait_transfer(seen);
      if (seen) begin
         check_length(5'(insn.size()), f_bytes_read);
         check_bundle(exp_s0, s0);
      end
      next_cycle();
      f_valid = 1'b0;
      next_pc = next_pc + 32'(insn.size());
   endtask

   task automatic transfer_insn();
      drive_window(insn.size());
      complete_transfer();
   endtask

   task automatic send_insn(input logic [23:0] pfx, input int npfx, input logic [7:0] op,
                            input logic [7:0] op2, input logic [7:0] modrm,
                            input logic [7:0] sib);
      build_insn(pfx, npfx, op, op2, modrm, sib);
      transfer_insn();
   endtask

   task automatic test_reset();
      start_test("reset");
      @(negedge clk);
      check_flag("s0_valid", 1'b0, s0_valid);
      check_flag("f_ready", 1'b0, f_ready);
      check_flag("halt", 1'b0, halt);
      next_cycle();
      finish_test();
   endtask

   task automatic test_fields();
      start_test("length_fields");
      // No operands, known and unknown
      send_insn(24'h000000, 0, 8'h90, 8'h00, 8'h00, 8'h00);
      send_insn(24'h000000, 0, 8'hC3, 8'h00, 8'h00, 8'h00);
      send_insn(24'h000000, 0, 8'hFE, 8'h00, 8'h00, 8'h00);
      send_insn(24'h000000, 0, 8'h0F, 8'h05, 8'h00, 8'h00);
      // Immediates
      send_insn(24'h000000, 0, 8'h04, 8'h00, 8'h00, 8'h00);
      send_insn(24'h000000, 0, 8'hEB, 8'h00, 8'h00, 8'h00);
      send_insn(24'h000000, 0, 8'h05, 8'h00, 8'h00, 8'h00);
      send_insn(24'h660000, 1, 8'h05, 8'h00, 8'h00, 8'h00);
      send_insn(24'h000000, 0, 8'hB8, 8'h00, 8'h00, 8'h00);
      send_insn(24'h660000, 1, 8'hBF, 8'h00, 8'h00, 8'h00);
      send_insn(24'h000000, 0, 8'hE8, 8'h00, 8'h00, 8'h00);
      send_insn(24'h660000, 1, 8'hE8, 8'h00, 8'h00, 8'h00);
      send_insn(24'h000000, 0, 8'h0F, 8'h84, 8'h00, 8'h00);
      send_insn(24'h660000, 1, 8'h0F, 8'h8F, 8'h00, 8'h00);
      // ModRM classes
      send_insn(24'h000000, 0, 8'h0F, 8'hAF, 8'hC8, 8'h00);
      send_insn(24'h000000, 0, 8'h89, 8'h00, 8'hD8, 8'h00);
      send_insn(24'h000000, 0, 8'h8B, 8'h00, 8'h08, 8'h00);
      send_insn(24'h000000, 0, 8'h01, 8'h00, 8'h05, 8'h00);
      send_insn(24'h000000, 0, 8'h03, 8'h00, 8'h45, 8'h00);
      send_insn(24'h000000, 0, 8'h88, 8'h00, 8'h85, 8'h00);
      // SIB forms, base 101 with each mod
      send_insn(24'h000000, 0, 8'h8B, 8'h00, 8'h04, 8'h88);
      send_insn(24'h000000, 0, 8'h89, 8'h00, 8'h04, 8'h25);
      send_insn(24'h000000, 0, 8'h01, 8'h00, 8'h44, 8'h25);
      send_insn(24'h000000, 0, 8'h02, 8'h00, 8'h84, 8'h25);
      // Immediate with ModRM, prefixes
      send_insn(24'h000000, 0, 8'hC6, 8'h00, 8'h45, 8'h00);
      send_insn(24'h660000, 1, 8'hC6, 8'h00, 8'h00, 8'h00);
      send_insn(24'h000000, 0, 8'hC7, 8'h00, 8'h05, 8'h00);
      send_insn(24'h660000, 1, 8'hC7, 8'h00, 8'hC0, 8'h00);
      send_insn(24'hF02E66, 3, 8'hC7, 8'h00, 8'h84, 8'h25);
      send_insn(24'h263665, 3, 8'h03, 8'h00, 8'h0C, 8'h65);
      send_insn(24'hF2F300, 2, 8'h0F, 8'hAF, 8'h04, 8'h25);
      finish_test();
   endtask

   task automatic test_partial();
      start_test("partial_window");
      build_insn(24'h660000, 1, 8'hC7, 8'h00, 8'h84, 8'h25);
      drive_window(insn.size() - 1);
      f_valid  = 1'b1;
      s0_ready = 1'b1;
      @(negedge clk);
      check_flag("s0_valid", 1'b0, s0_valid);
      check_flag("f_ready", 1'b0, f_ready);
      next_cycle();
      // The last byte arrives
      fetch.valid_bytes = 5'(insn.size());
      complete_transfer();
      finish_test();
   endtask

   task automatic test_backpressure();
      start_test("back_pressure");
      build_insn(24'h000000, 0, 8'hE8, 8'h00, 8'h00, 8'h00);
      drive_window(insn.size());
      f_valid  = 1'b1;
      s0_ready = 1'b0;
      repeat (3) begin
         @(negedge clk);
         check_flag("s0_valid", 1'b1, s0_valid);
         check_flag("f_ready", 1'b0, f_ready);
         check_bundle(exp_s0, s0);
         next_cycle();
      end
      complete_transfer();
      finish_test();
   endtask

   task automatic test_halt(input logic use_int);
      if (use_int)
         start_test("halt_int");
      else
         start_test("halt_flush");
      send_insn(24'h000000, 0, 8'hF4, 8'h00, 8'h00, 8'h00);
      // A NOP waits behind the halt
      build_insn(24'h000000, 0, 8'h90, 8'h00, 8'h00, 8'h00);
      drive_window(insn.size());
      f_valid = 1'b1;
      @(negedge clk);
      check_flag("halt", 1'b1, halt);
      check_flag("s0_valid", 1'b0, s0_valid);
      check_flag("f_ready", 1'b0, f_ready);
      next_cycle();
      handle_int = use_int;
      flush      = ~use_int;
      next_cycle();
      handle_int = 1'b0;
      flush      = 1'b0;
      check_flag("halt", 1'b0, halt);
      complete_transfer();
      finish_test();
   endtask

   task automatic test_random();
      logic [23:0] pfx;
      int          npfx;
      logic [7:0]  op;
      logic [7:0]  op2;
      logic [7:0]  modrm;
      logic [7:0]  sib;
      start_test("random_stream");
      for (int i = 0; i < random_count; i++) begin
         npfx = int'(rand_bits(2));
         pfx  = '0;
         for (int k = 0; k < npfx; k++)
            pfx[23-8*k -: 8] = pick_prefix(3'(rand_bits(3)));
         op2 = 8'h00;
         if (rand_bits(3) == 0) begin
            op = 8'h0F;
            if (rand_bits(1) == 1)
               op2 = 8'hAF;
            else
               op2 = {4'h8, 4'(rand_bits(4))};
         end else begin
            op = pick_opcode(4'(rand_bits(4)));
         end
         modrm = 8'(rand_bits(8));
         sib   = 8'(rand_bits(8));
         send_insn(pfx, npfx, op, op2, modrm, sib);
      end
      finish_test();
   endtask

   initial begin
      lfsr_state   = 16'd1934;
      arst_n       = 1'b0;
      flush        = 1'b0;
      handle_int   = 1'b0;
      f_valid      = 1'b0;
      s0_ready     = 1'b0;
      fetch        = '0;
      next_pc      = 32'h0000_1000;
      error_count  = 0;
      test_count   = 0;
      failed_tests = 0;
      repeat (5) @(posedge clk);
      #drive_delay;
      arst_n = 1'b1;
      test_reset();
      test_fields();
      test_partial();
      test_backpressure();
      test_halt(1'b1);
      test_halt(1'b0);
      test_random();
      $display("tests %0d, failed %0d, errors %0d", test_count, failed_tests, error_count);
      if (error_count == 0)
         $display("Regression passed");
      else
         $display("Regression failed");
      $finish;
   end

endmodule

// File: sources.f
hdl/decode_pkg.sv
hdl/prefix_scan.sv
hdl/opcode_decode.sv
hdl/modrm_decode.sv
hdl/field_align.sv
hdl/decode_control.sv
hdl/decode_stage_0.sv
verification/tb_clock.sv
verification/decode_stage_0_tb.sv

// File: run.sh
#!/bin/sh
# Compile and run with Verilator; the log decides pass or fail
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f sources.f --top-module decode_stage_0_tb \
   -o decode_stage_0_tb > sim.log 2>&1 &&
   ./obj_dir/decode_stage_0_tb >> sim.log 2>&1 ||
   echo "Regression failed" >> sim.log
grep -q "Regression failed" sim.log && echo "FAIL (see sim.log)" && exit 1
echo "PASS"
exit 0
